// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_ingress_fifo -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

// ==== ingress_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module ingress_arbiter (
	input wire clk_ram_ctl,
	input wire rst,
	input wire port_frame_ready [`INGRESS_NUM_PORTS],
	input wire [`INGRESS_LEN_BITS-1:0] port_frame_bytelen [`INGRESS_NUM_PORTS],
	input wire port_mem_valid [`INGRESS_NUM_PORTS],
	input wire ingress_fifo_pkg::frame_word_u port_mem_data [`INGRESS_NUM_PORTS],
	input wire port_frame_done [`INGRESS_NUM_PORTS],
	output logic port_frame_start [`INGRESS_NUM_PORTS],
	output logic wr_en,
	output logic [`INGRESS_PORT_BITS-1:0] wr_port,
	output ingress_fifo_pkg::frame_word_u wr_data,
	output logic wr_last,
	output logic [`INGRESS_LEN_BITS-1:0] wr_len
);

	localparam int NP = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;

	logic [PB-1:0] rr_port;
	logic [PB-1:0] next_port;
	logic next_valid;
	logic busy;
	logic [PB-1:0] cur_port;
	logic [`INGRESS_LEN_BITS-1:0] cur_len;
	logic start;

	////////////////////////////////////////////////////////////////////////////
	// Port selection

	// Round-robin port if it has a frame
	// Otherwise the highest-numbered ready port, so the last hit wins
	always_comb begin
		next_port = rr_port;
		next_valid = port_frame_ready[rr_port];
		if (!next_valid) begin
			for (int i = 0; i < NP; i++) begin
				if (port_frame_ready[i]) begin
					next_port = PB'(i);
					next_valid = 1'b1;
				end
			end
		end
	end

	// Start when idle, or back to back on the done word of the current frame
	assign start = next_valid && (!busy || port_frame_done[cur_port]);

	always_comb begin
		for (int i = 0; i < NP; i++)
			port_frame_start[i] = start && (next_port == PB'(i));
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame tracking and write stream

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			rr_port <= '0;
			busy <= 1'b0;
			cur_port <= '0;
			wr_en <= 1'b0;
			wr_last <= 1'b0;
		end else begin
			if (busy && port_frame_done[cur_port])
				busy <= 1'b0;
			// New frame owns the stream from the next cycle on
			if (start) begin
				busy <= 1'b1;
				rr_port <= rr_port + 1'b1;
				cur_port <= next_port;
			end
			wr_en <= port_mem_valid[cur_port];
			wr_last <= port_mem_valid[cur_port] && port_frame_done[cur_port];
		end
	end

	// Word and length follow the current port one stage later
	always_ff @(posedge clk_ram_ctl) begin
		wr_port <= cur_port;
		wr_data <= port_mem_data[cur_port];
		wr_len <= cur_len;
		// Source holds its length until the last word
		if (start)
			cur_len <= port_frame_bytelen[next_port];
	end

	// Words come only from the granted port while its frame is open
	for (genvar g = 0; g < NP; g++) begin : g_stream_chk
		assert property (@(posedge clk_ram_ctl) disable iff (rst)
			port_mem_valid[g] |-> (busy && cur_port == PB'(g)));
	end

endmodule

`default_nettype wire

// ==== ingress_fifo_params.svh ====
`ifndef INGRESS_FIFO_PARAMS_SVH
`define INGRESS_FIFO_PARAMS_SVH

// Ingress ports and port number width
`define INGRESS_NUM_PORTS 4
`define INGRESS_PORT_BITS 2

// Per-port SRAM region of 256 words
`define INGRESS_PTR_BITS 8

// Port number above the word pointer
`define INGRESS_ADDR_BITS 10

// SRAM and stream word, 16 bytes
`define INGRESS_WORD_BITS 128

// Frame length in bytes
`define INGRESS_LEN_BITS 11

// Committed frames waiting per port
`define INGRESS_META_DEPTH 8

// Reads in flight to the SRAM
`define INGRESS_TAG_DEPTH 16

// Prefetch words per port, one whole frame
`define INGRESS_PREFETCH_DEPTH 16

`endif

// ==== ingress_fifo_pkg.sv ====
`default_nettype none

`include "ingress_fifo_params.svh"

package ingress_fifo_pkg;

	// Leading fields of the first word of a frame
	// Destination MAC in the top bits
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] rest;
	} mac_hdr_t;

	// One word as stored in SRAM and streamed out
	// Raw view for the data path
	// Header view for MAC capture on the first word
	typedef union packed {
		logic [`INGRESS_WORD_BITS-1:0] raw;
		mac_hdr_t hdr;
	} frame_word_u;

endpackage

`default_nettype wire

// ==== ingress_fifo_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module ingress_fifo_top (
	input wire clk_ram_ctl,
	input wire rst,

	// Ingress ports
	input wire port_frame_ready [`INGRESS_NUM_PORTS],
	input wire [`INGRESS_LEN_BITS-1:0] port_frame_bytelen [`INGRESS_NUM_PORTS],
	output wire port_frame_start [`INGRESS_NUM_PORTS],
	input wire port_mem_valid [`INGRESS_NUM_PORTS],
	input wire ingress_fifo_pkg::frame_word_u port_mem_data [`INGRESS_NUM_PORTS],
	input wire port_frame_done [`INGRESS_NUM_PORTS],

	// External SRAM
	output wire ram_wr_en,
	output wire [`INGRESS_ADDR_BITS-1:0] ram_wr_addr,
	output wire ingress_fifo_pkg::frame_word_u ram_wr_data,
	output wire ram_rd_en,
	output wire [`INGRESS_ADDR_BITS-1:0] ram_rd_addr,
	input wire ram_rd_valid,
	input wire ingress_fifo_pkg::frame_word_u ram_rd_data,

	// Switch fabric
	output wire fabric_ready [`INGRESS_NUM_PORTS],
	output wire [47:0] fabric_dst_mac [`INGRESS_NUM_PORTS],
	output wire [47:0] fabric_src_mac [`INGRESS_NUM_PORTS],
	output wire [`INGRESS_LEN_BITS-1:0] fabric_bytelen [`INGRESS_NUM_PORTS],
	input wire forward_en [`INGRESS_NUM_PORTS],
	output wire frame_valid,
	output wire frame_last,
	output wire ingress_fifo_pkg::frame_word_u frame_data
);

	import ingress_fifo_pkg::*;

	localparam int NP = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;
	localparam int LB = `INGRESS_LEN_BITS;

	// Merged write stream
	wire wr_en;
	wire [PB-1:0] wr_port;
	wire frame_word_u wr_data;
	wire wr_last;
	wire [LB-1:0] wr_len;

	// Frame commits and metadata
	wire meta_wr [NP];
	wire [LB-1:0] meta_len;
	wire meta_rd [NP];
	wire meta_empty [NP];
	wire [LB-1:0] meta_dout [NP];

	// Read tags and prefetch
	wire [PB-1:0] tag_port;
	wire pf_wr;
	wire [PB-1:0] pf_wr_channel;
	wire frame_word_u pf_wr_data;
	wire pf_rd;
	wire [PB-1:0] pf_rd_channel;

	////////////////////////////////////////////////////////////////////////////
	// Write side

	ingress_arbiter arbiter (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.port_frame_ready(port_frame_ready),
		.port_frame_bytelen(port_frame_bytelen),
		.port_mem_valid(port_mem_valid),
		.port_mem_data(port_mem_data),
		.port_frame_done(port_frame_done),
		.port_frame_start(port_frame_start),
		.wr_en(wr_en),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_len(wr_len)
	);

	sram_write_addr write_addr (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.wr_en(wr_en),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_len(wr_len),
		.ram_wr_en(ram_wr_en),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data),
		.meta_wr(meta_wr),
		.meta_len(meta_len)
	);

	// Byte lengths of committed frames, one FIFO per port
	for (genvar g = 0; g < NP; g++) begin : g_meta
		sync_fifo #(
			.WIDTH(LB),
			.DEPTH(`INGRESS_META_DEPTH)
		) meta_fifo (
			.clk_ram_ctl(clk_ram_ctl),
			.rst(rst),
			.wr(meta_wr[g]),
			.din(meta_len),
			.rd(meta_rd[g]),
			.dout(meta_dout[g]),
			.empty(meta_empty[g]),
			.full()
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side

	// Port number of each SRAM read, popped as data returns in order
	sync_fifo #(
		.WIDTH(PB),
		.DEPTH(`INGRESS_TAG_DEPTH)
	) tag_fifo (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.wr(ram_rd_en),
		.din(ram_rd_addr[`INGRESS_ADDR_BITS-1:`INGRESS_PTR_BITS]),
		.rd(ram_rd_valid),
		.dout(tag_port),
		.empty(),
		.full()
	);

	prefetch_buffer prefetch (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.wr(pf_wr),
		.wr_channel(pf_wr_channel),
		.wr_data(pf_wr_data),
		.rd(pf_rd),
		.rd_channel(pf_rd_channel),
		.rd_data(frame_data)
	);

	readout_ctl readout (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.meta_empty(meta_empty),
		.meta_len(meta_dout),
		.ram_rd_valid(ram_rd_valid),
		.ram_rd_data(ram_rd_data),
		.rd_tag_port(tag_port),
		.forward_en(forward_en),
		.meta_rd(meta_rd),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.pf_wr(pf_wr),
		.pf_wr_channel(pf_wr_channel),
		.pf_wr_data(pf_wr_data),
		.pf_rd(pf_rd),
		.pf_rd_channel(pf_rd_channel),
		.fabric_ready(fabric_ready),
		.fabric_dst_mac(fabric_dst_mac),
		.fabric_src_mac(fabric_src_mac),
		.fabric_bytelen(fabric_bytelen),
		.frame_valid(frame_valid),
		.frame_last(frame_last)
	);

endmodule

`default_nettype wire

// ==== prefetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module prefetch_buffer (
	input wire clk_ram_ctl,
	input wire rst,
	input wire wr,
	input wire [`INGRESS_PORT_BITS-1:0] wr_channel,
	input wire ingress_fifo_pkg::frame_word_u wr_data,
	input wire rd,
	input wire [`INGRESS_PORT_BITS-1:0] rd_channel,
	output ingress_fifo_pkg::frame_word_u rd_data
);

	import ingress_fifo_pkg::*;

	localparam int NP = `INGRESS_NUM_PORTS;
	localparam int DEPTH = `INGRESS_PREFETCH_DEPTH;
	localparam int AW = $clog2(DEPTH);

	// One RAM, each channel owns a contiguous slice of DEPTH words
	frame_word_u mem [NP*DEPTH];

	// Circular pointers per channel, MSB marks the lap
	logic [AW:0] wr_ptr [NP];
	logic [AW:0] rd_ptr [NP];
	logic wr_full;

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			for (int i = 0; i < NP; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
			end
		end else begin
			if (wr)
				wr_ptr[wr_channel] <= wr_ptr[wr_channel] + 1'b1;
			if (rd)
				rd_ptr[rd_channel] <= rd_ptr[rd_channel] + 1'b1;
		end
	end

	// Channel number selects the slice, pointer the word in it
	always_ff @(posedge clk_ram_ctl) begin
		if (wr)
			mem[{wr_channel, wr_ptr[wr_channel][AW-1:0]}] <= wr_data;
		if (rd)
			rd_data <= mem[{rd_channel, rd_ptr[rd_channel][AW-1:0]}];
	end

	assign wr_full = (wr_ptr[wr_channel][AW] != rd_ptr[wr_channel][AW]) &&
		(wr_ptr[wr_channel][AW-1:0] == rd_ptr[wr_channel][AW-1:0]);

	// Readout never prefetches more than one frame of DEPTH words per channel
	assert property (@(posedge clk_ram_ctl) disable iff (rst) wr |-> !wr_full);

endmodule

`default_nettype wire

// ==== readout_ctl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module readout_ctl (
	input wire clk_ram_ctl,
	input wire rst,
	input wire meta_empty [`INGRESS_NUM_PORTS],
	input wire [`INGRESS_LEN_BITS-1:0] meta_len [`INGRESS_NUM_PORTS],
	input wire ram_rd_valid,
	input wire ingress_fifo_pkg::frame_word_u ram_rd_data,
	input wire [`INGRESS_PORT_BITS-1:0] rd_tag_port,
	input wire forward_en [`INGRESS_NUM_PORTS],
	output logic meta_rd [`INGRESS_NUM_PORTS],
	output logic ram_rd_en,
	output logic [`INGRESS_ADDR_BITS-1:0] ram_rd_addr,
	output logic pf_wr,
	output logic [`INGRESS_PORT_BITS-1:0] pf_wr_channel,
	output ingress_fifo_pkg::frame_word_u pf_wr_data,
	output logic pf_rd,
	output logic [`INGRESS_PORT_BITS-1:0] pf_rd_channel,
	output logic fabric_ready [`INGRESS_NUM_PORTS],
	output logic [47:0] fabric_dst_mac [`INGRESS_NUM_PORTS],
	output logic [47:0] fabric_src_mac [`INGRESS_NUM_PORTS],
	output logic [`INGRESS_LEN_BITS-1:0] fabric_bytelen [`INGRESS_NUM_PORTS],
	output logic frame_valid,
	output logic frame_last
);

	localparam int NP = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;
	localparam int LB = `INGRESS_LEN_BITS;
	// Word counts up to a full prefetch channel
	localparam int CB = $clog2(`INGRESS_PREFETCH_DEPTH) + 1;

	// Per-port readout states
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_PREFETCH = 3'd1;
	localparam logic [2:0] ST_PREFETCH_WAIT = 3'd2;
	localparam logic [2:0] ST_READY = 3'd3;
	localparam logic [2:0] ST_FORWARD = 3'd4;
	localparam logic [2:0] ST_LAST = 3'd5;

	logic [2:0] state [NP];
	logic [`INGRESS_PTR_BITS-1:0] rd_ptr [NP];
	// Reads issued and words returned for the current frame
	logic [CB-1:0] rd_count [NP];
	logic [CB-1:0] rx_count [NP];
	logic [CB-1:0] frame_words [NP];
	// Only one port forwards at a time, so one counter serves all
	logic [CB-1:0] fwd_count;
	logic [NP-1:0] rd_grant;
	logic [PB-1:0] rd_port;
	logic [NP-1:0] fwd_vec;

	// Frame length in words, rounded up to whole words
	always_comb begin
		for (int i = 0; i < NP; i++) begin
			frame_words[i] = CB'(fabric_bytelen[i][LB-1:4]) + CB'(|fabric_bytelen[i][3:0]);
			fwd_vec[i] = forward_en[i];
		end
	end

	// Single SRAM read slot, lowest-numbered prefetching port wins
	always_comb begin
		rd_grant = '0;
		rd_port = '0;
		for (int i = NP - 1; i >= 0; i--) begin
			if (state[i] == ST_PREFETCH) begin
				rd_grant = NP'(1) << i;
				rd_port = PB'(i);
			end
		end
	end

	// Returned words go to the channel of the port the tag names
	assign pf_wr = ram_rd_valid;
	assign pf_wr_channel = rd_tag_port;
	assign pf_wr_data = ram_rd_data;

	////////////////////////////////////////////////////////////////////////////
	// Readout state machines

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			ram_rd_en <= 1'b0;
			pf_rd <= 1'b0;
			pf_rd_channel <= '0;
			frame_valid <= 1'b0;
			frame_last <= 1'b0;
			fwd_count <= '0;
			for (int i = 0; i < NP; i++) begin
				state[i] <= ST_IDLE;
				meta_rd[i] <= 1'b0;
				fabric_ready[i] <= 1'b0;
				rd_ptr[i] <= '0;
				rd_count[i] <= '0;
				rx_count[i] <= '0;
			end
		end else begin
			ram_rd_en <= |rd_grant;
			pf_rd <= 1'b0;
			// Buffer data shows up one cycle after its read strobe
			frame_valid <= pf_rd;
			frame_last <= 1'b0;

			if (ram_rd_valid)
				rx_count[rd_tag_port] <= rx_count[rd_tag_port] + 1'b1;

			for (int i = 0; i < NP; i++) begin
				meta_rd[i] <= 1'b0;
				case (state[i])
					// Length is taken from the FIFO head, pop follows a cycle later
					ST_IDLE: begin
						if (!meta_empty[i]) begin
							meta_rd[i] <= 1'b1;
							rd_count[i] <= '0;
							rx_count[i] <= '0;
							state[i] <= ST_PREFETCH;
						end
					end
					ST_PREFETCH: begin
						if (rd_grant[i]) begin
							rd_ptr[i] <= rd_ptr[i] + 1'b1;
							rd_count[i] <= rd_count[i] + 1'b1;
							if (rd_count[i] == frame_words[i] - 1'b1)
								state[i] <= ST_PREFETCH_WAIT;
						end
					end
					// All words back means the MACs are in too
					ST_PREFETCH_WAIT: begin
						if (rx_count[i] == frame_words[i]) begin
							fabric_ready[i] <= 1'b1;
							state[i] <= ST_READY;
						end
					end
					ST_READY: begin
						if (forward_en[i]) begin
							fabric_ready[i] <= 1'b0;
							fwd_count <= '0;
							state[i] <= ST_FORWARD;
						end
					end
					// One buffer read per cycle for the whole frame
					ST_FORWARD: begin
						pf_rd <= 1'b1;
						pf_rd_channel <= PB'(i);
						fwd_count <= fwd_count + 1'b1;
						if (fwd_count == frame_words[i] - 1'b1)
							state[i] <= ST_LAST;
					end
					// Final word is on the output now
					ST_LAST: begin
						frame_last <= 1'b1;
						state[i] <= ST_IDLE;
					end
					default: state[i] <= ST_IDLE;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read address and fabric metadata

	always_ff @(posedge clk_ram_ctl) begin
		ram_rd_addr <= {rd_port, rd_ptr[rd_port]};
		for (int i = 0; i < NP; i++) begin
			if (state[i] == ST_IDLE && !meta_empty[i])
				fabric_bytelen[i] <= meta_len[i];
		end
		// First returned word of a frame, header view
		if (ram_rd_valid && rx_count[rd_tag_port] == '0) begin
			fabric_dst_mac[rd_tag_port] <= ram_rd_data.hdr.dst_mac;
			fabric_src_mac[rd_tag_port] <= ram_rd_data.hdr.src_mac;
		end
	end

	// Fabric grants one port per forward
	assert property (@(posedge clk_ram_ctl) disable iff (rst) $onehot0(fwd_vec));

	// Committed frames fit a prefetch channel and carry a full header
	for (genvar g = 0; g < NP; g++) begin : g_len_chk
		assert property (@(posedge clk_ram_ctl) disable iff (rst)
			(state[g] == ST_IDLE && !meta_empty[g]) |->
			(meta_len[g] >= LB'(64) && meta_len[g] <= LB'(256)));
	end

endmodule

`default_nettype wire

// ==== sram_write_addr.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module sram_write_addr (
	input wire clk_ram_ctl,
	input wire rst,
	input wire wr_en,
	input wire [`INGRESS_PORT_BITS-1:0] wr_port,
	input wire ingress_fifo_pkg::frame_word_u wr_data,
	input wire wr_last,
	input wire [`INGRESS_LEN_BITS-1:0] wr_len,
	output logic ram_wr_en,
	output logic [`INGRESS_ADDR_BITS-1:0] ram_wr_addr,
	output ingress_fifo_pkg::frame_word_u ram_wr_data,
	output logic meta_wr [`INGRESS_NUM_PORTS],
	output logic [`INGRESS_LEN_BITS-1:0] meta_len
);

	localparam int NP = `INGRESS_NUM_PORTS;
	localparam int PB = `INGRESS_PORT_BITS;

	// Next free word in each port region, wraps at the region size
	logic [`INGRESS_PTR_BITS-1:0] wr_ptr [NP];

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			ram_wr_en <= 1'b0;
			for (int i = 0; i < NP; i++) begin
				meta_wr[i] <= 1'b0;
				wr_ptr[i] <= '0;
			end
		end else begin
			ram_wr_en <= wr_en;
			// Commit lines up with the write of the last word
			for (int i = 0; i < NP; i++)
				meta_wr[i] <= wr_en && wr_last && (wr_port == PB'(i));
			if (wr_en)
				wr_ptr[wr_port] <= wr_ptr[wr_port] + 1'b1;
		end
	end

	// Port number on top of the region pointer
	always_ff @(posedge clk_ram_ctl) begin
		ram_wr_addr <= {wr_port, wr_ptr[wr_port]};
		ram_wr_data <= wr_data;
		meta_len <= wr_len;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
ingress_fifo_pkg.sv
sync_fifo.sv
ingress_arbiter.sv
sram_write_addr.sv
prefetch_buffer.sv
readout_ctl.sv
ingress_fifo_top.sv
tb_ingress_fifo.sv

// ==== sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input wire clk_ram_ctl,
	input wire rst,
	input wire wr,
	input wire [WIDTH-1:0] din,
	input wire rd,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];

	// Extra MSB tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_ram_ctl) begin
		if (wr)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	// Head entry, visible without a read strobe
	assign dout = mem[rd_ptr[AW-1:0]];

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Producers never push into a full FIFO
	assert property (@(posedge clk_ram_ctl) disable iff (rst) wr |-> !full);

	// Consumers only pop what has been committed
	assert property (@(posedge clk_ram_ctl) disable iff (rst) rd |-> !empty);

endmodule

`default_nettype wire

// ==== tb_ingress_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ingress_fifo_params.svh"

module tb_ingress_fifo;

	import ingress_fifo_pkg::*;

	localparam int NP = `INGRESS_NUM_PORTS;
	// Frames generated per port, 40 in all
	localparam int NF = 10;
	localparam int MAX_WORDS = 16;
	// Budget of 40 cycles per frame plus a margin for the random gaps
	localparam int MAX_CYCLES = 40 * 40 + 1000;
	localparam int RD_LAT = 6;

	logic clk_ram_ctl;
	logic rst;

	// Port sources
	logic port_frame_ready [NP];
	logic [`INGRESS_LEN_BITS-1:0] port_frame_bytelen [NP];
	wire port_frame_start [NP];
	logic port_mem_valid [NP];
	frame_word_u port_mem_data [NP];
	logic port_frame_done [NP];

	// SRAM
	wire ram_wr_en;
	wire [`INGRESS_ADDR_BITS-1:0] ram_wr_addr;
	wire frame_word_u ram_wr_data;
	wire ram_rd_en;
	wire [`INGRESS_ADDR_BITS-1:0] ram_rd_addr;
	logic ram_rd_valid;
	frame_word_u ram_rd_data;

	// Fabric
	wire fabric_ready [NP];
	wire [47:0] fabric_dst_mac [NP];
	wire [47:0] fabric_src_mac [NP];
	wire [`INGRESS_LEN_BITS-1:0] fabric_bytelen [NP];
	logic forward_en [NP];
	wire frame_valid;
	wire frame_last;
	wire frame_word_u frame_data;

	// Generated frames
	logic [127:0] fw [NP][NF][MAX_WORDS];
	int flen [NP][NF];
	int fwords [NP][NF];

	// SRAM model storage and read pipeline
	logic [127:0] sram [1 << `INGRESS_ADDR_BITS];
	logic pipe_v [RD_LAT];
	logic [127:0] pipe_d [RD_LAT];

	// Source side state
	int src_state [NP];
	int src_idx [NP];
	int src_word [NP];

	// Arbiter model
	int rr_m;
	logic busy_m;
	int cur_m;

	// Write model, pointers walk the frames of each port in order
	logic [7:0] wptr_m [NP];
	int wr_f [NP];
	int wr_w [NP];
	// Port of each source word, two stages ahead of its SRAM write
	int wr_src [2];

	// Read model, per-port pointers over the written words
	logic [7:0] rptr_m [NP];

	// Delivery model
	int deliv_idx [NP];
	logic prev_ready [NP];
	logic out_active;
	int out_port;
	int out_word;
	int fwd_cyc;
	int cyc;

	int unsigned seed_val;

	ingress_fifo_top ingress_fifo_top_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.port_frame_ready(port_frame_ready),
		.port_frame_bytelen(port_frame_bytelen),
		.port_frame_start(port_frame_start),
		.port_mem_valid(port_mem_valid),
		.port_mem_data(port_mem_data),
		.port_frame_done(port_frame_done),
		.ram_wr_en(ram_wr_en),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.ram_rd_valid(ram_rd_valid),
		.ram_rd_data(ram_rd_data),
		.fabric_ready(fabric_ready),
		.fabric_dst_mac(fabric_dst_mac),
		.fabric_src_mac(fabric_src_mac),
		.fabric_bytelen(fabric_bytelen),
		.forward_en(forward_en),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_data(frame_data)
	);

	// 40 ns period
	always #20 clk_ram_ctl = ~clk_ram_ctl;

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame generation and reset

	initial begin
		seed_val = $urandom(32'h2aab);
		clk_ram_ctl = 1'b0;
		rst = 1'b1;
		ram_rd_valid = 1'b0;
		ram_rd_data = '0;
		// Read pipeline empty from the start
		for (int k = 0; k < RD_LAT; k++)
			pipe_v[k] = 1'b0;
		for (int p = 0; p < NP; p++) begin
			port_frame_ready[p] = 1'b0;
			port_frame_bytelen[p] = '0;
			port_mem_valid[p] = 1'b0;
			port_mem_data[p] = '0;
			port_frame_done[p] = 1'b0;
			forward_en[p] = 1'b0;
			// Byte length 64 to 256, word count rounded up
			for (int f = 0; f < NF; f++) begin
				flen[p][f] = 64 + int'($urandom % 193);
				fwords[p][f] = (flen[p][f] + 15) / 16;
				for (int w = 0; w < MAX_WORDS; w++)
					fw[p][f][w] = {$urandom, $urandom, $urandom, $urandom};
			end
		end
		repeat (4) @(posedge clk_ram_ctl);
		rst <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM model, in-order reads after a fixed latency

	always @(posedge clk_ram_ctl) begin
		if (ram_wr_en)
			sram[ram_wr_addr] <= ram_wr_data.raw;
		pipe_v[0] <= !rst && ram_rd_en;
		pipe_d[0] <= sram[ram_rd_addr];
		for (int k = 1; k < RD_LAT; k++) begin
			pipe_v[k] <= pipe_v[k-1];
			pipe_d[k] <= pipe_d[k-1];
		end
		ram_rd_valid <= pipe_v[RD_LAT-1];
		ram_rd_data.raw <= pipe_d[RD_LAT-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks on sampled outputs, then drive the next inputs

	always @(posedge clk_ram_ctl) begin
		int sel;
		logic any_rdy;
		logic exp_start;
		int p;
		int f;
		logic all_done;
		int r;

		if (rst) begin
			cyc = 0;
			rr_m = 0;
			busy_m = 1'b0;
			cur_m = 0;
			out_active = 1'b0;
			wr_src[0] = -1;
			wr_src[1] = -1;
			for (int i = 0; i < NP; i++) begin
				src_state[i] = 0;
				src_idx[i] = 0;
				src_word[i] = 0;
				wptr_m[i] = '0;
				rptr_m[i] = '0;
				wr_f[i] = 0;
				wr_w[i] = 0;
				deliv_idx[i] = 0;
				prev_ready[i] = 1'b0;
			end
		end else begin
			// Control outputs quiet right after reset
			if (cyc == 0) begin
				check_value("ram_wr_en", ram_wr_en, 0);
				check_value("ram_rd_en", ram_rd_en, 0);
				check_value("frame_valid", frame_valid, 0);
				check_value("frame_last", frame_last, 0);
				for (int i = 0; i < NP; i++) begin
					check_value("port_frame_start", port_frame_start[i], 0);
					check_value("fabric_ready", fabric_ready[i], 0);
				end
			end

			// Round-robin port first, else the highest-numbered ready one
			any_rdy = 1'b0;
			sel = rr_m;
			if (port_frame_ready[rr_m])
				any_rdy = 1'b1;
			else
				for (int i = 0; i < NP; i++)
					if (port_frame_ready[i]) begin
						sel = i;
						any_rdy = 1'b1;
					end
			exp_start = any_rdy && (!busy_m || port_frame_done[cur_m]);
			for (int i = 0; i < NP; i++)
				check_value("port_frame_start", port_frame_start[i], exp_start && sel == i);
			if (busy_m && port_frame_done[cur_m])
				busy_m = 1'b0;
			if (exp_start) begin
				busy_m = 1'b1;
				rr_m = (rr_m + 1) % NP;
				cur_m = sel;
			end

			// SRAM write 2 cycles after the source word, in that source's region
			check_value("ram_wr_en", ram_wr_en, wr_src[1] >= 0);
			if (ram_wr_en) begin
				p = wr_src[1];
				if (wr_f[p] >= NF)
					stop_with_error("SRAM write after the last frame of a port");
				check_value("ram_wr_addr", ram_wr_addr, {p[1:0], wptr_m[p]});
				check_value("ram_wr_data", ram_wr_data.raw, fw[p][wr_f[p]][wr_w[p]]);
				wptr_m[p] = wptr_m[p] + 8'd1;
				wr_w[p]++;
				if (wr_w[p] == fwords[p][wr_f[p]]) begin
					wr_w[p] = 0;
					wr_f[p]++;
				end
			end
			wr_src[1] = wr_src[0];
			wr_src[0] = -1;
			for (int i = 0; i < NP; i++)
				if (port_mem_valid[i])
					wr_src[0] = i;

			// SRAM reads walk each port region in order over written words
			if (ram_rd_en) begin
				p = int'(ram_rd_addr[`INGRESS_ADDR_BITS-1:`INGRESS_PTR_BITS]);
				if (rptr_m[p] >= wptr_m[p])
					stop_with_error("SRAM read of a word that was never written");
				check_value("ram_rd_addr", ram_rd_addr[`INGRESS_PTR_BITS-1:0], rptr_m[p]);
				rptr_m[p] = rptr_m[p] + 8'd1;
			end

			// Fabric metadata of the oldest undelivered frame
			for (int i = 0; i < NP; i++) begin
				if (fabric_ready[i] && !prev_ready[i]) begin
					f = deliv_idx[i];
					if (f >= NF)
						stop_with_error("fabric_ready raised with no frame left");
					check_value("fabric_dst_mac", fabric_dst_mac[i], fw[i][f][0][127:80]);
					check_value("fabric_src_mac", fabric_src_mac[i], fw[i][f][0][79:32]);
					check_value("fabric_bytelen", fabric_bytelen[i], flen[i][f]);
				end
				prev_ready[i] = fabric_ready[i];
			end

			// Output stream, first word 2 cycles after the sampling edge
			if (out_active && cyc == fwd_cyc + 2)
				check_value("fabric_ready", fabric_ready[out_port], 0);
			if (out_active && cyc >= fwd_cyc + 4) begin
				f = deliv_idx[out_port];
				check_value("frame_valid", frame_valid, 1);
				check_value("frame_data", frame_data.raw, fw[out_port][f][out_word]);
				check_value("frame_last", frame_last, out_word == fwords[out_port][f] - 1);
				out_word++;
				if (out_word == fwords[out_port][f]) begin
					deliv_idx[out_port]++;
					out_active = 1'b0;
				end
			end else begin
				check_value("frame_valid", frame_valid, 0);
				check_value("frame_last", frame_last, 0);
			end

			// Port sources
			for (int i = 0; i < NP; i++) begin
				case (src_state[i])
					0: begin
						if (src_idx[i] < NF && src_idx[i] - deliv_idx[i] < 4 &&
							$urandom % 2 == 0) begin
							port_frame_ready[i] <= 1'b1;
							port_frame_bytelen[i] <= flen[i][src_idx[i]];
							src_state[i] = 1;
						end
					end
					1: begin
						if (port_frame_start[i]) begin
							port_frame_ready[i] <= 1'b0;
							port_mem_valid[i] <= 1'b1;
							port_mem_data[i].raw <= fw[i][src_idx[i]][0];
							port_frame_done[i] <= 1'b0;
							src_word[i] = 1;
							src_state[i] = 2;
						end
					end
					default: begin
						if (src_word[i] < fwords[i][src_idx[i]]) begin
							port_mem_data[i].raw <= fw[i][src_idx[i]][src_word[i]];
							port_frame_done[i] <= (src_word[i] == fwords[i][src_idx[i]] - 1);
							src_word[i]++;
						end else begin
							// Done word was taken on this edge
							port_mem_valid[i] <= 1'b0;
							port_frame_done[i] <= 1'b0;
							src_idx[i]++;
							src_state[i] = 0;
						end
					end
				endcase
			end

			// Fabric driver, one pulse on a ready port while the output is idle
			for (int i = 0; i < NP; i++)
				forward_en[i] <= 1'b0;
			if (!out_active && $urandom % 2 == 0) begin
				r = int'($urandom % NP);
				for (int k = 0; k < NP; k++) begin
					if (!out_active && fabric_ready[(r + k) % NP]) begin
						out_port = (r + k) % NP;
						forward_en[out_port] <= 1'b1;
						out_active = 1'b1;
						out_word = 0;
						fwd_cyc = cyc;
					end
				end
			end

			all_done = 1'b1;
			for (int i = 0; i < NP; i++)
				if (deliv_idx[i] != NF)
					all_done = 1'b0;
			if (all_done) begin
				$display("STATUS: PASS");
				$finish;
			end else begin
				if (cyc >= MAX_CYCLES)
					stop_with_error("Timeout before every frame was delivered");
				cyc++;
			end
		end
	end

endmodule

`default_nettype wire
